// ==== rtl/cpu_mem.sv ====
// Memory stage of the pipeline
// Drives the data memory port from the execute results and captures them,
// with the read data, into the memory/writeback register
`timescale 1ns/100ps
`include "mem_params.svh"

module cpu_mem (
	input logic clk,
	input logic rst,
	input logic cpu_stall,
	input mem_pkg::ex_mem_t ex,
	input mem_pkg::word_t wb_wdata,	// Value being written back this cycle
	input mem_pkg::word_t dmem_rdata,
	output mem_pkg::mem_wb_t p,
	output logic [`DMEM_AW-1:0] dmem_addr,
	output mem_pkg::word_t dmem_wdata,
	output logic dmem_we
);

	logic forward;	// Store operand comes from writeback

	// Byte address in, word index out
	assign dmem_addr = ex.alu_r[`DMEM_AW+1:2];

	// Older instruction in writeback targets the store source register
	assign forward = p.rfw && (ex.rt == p.rf_waddr) && (p.rf_waddr != `REG_ZERO);
	assign dmem_wdata = forward ? wb_wdata : ex.rfb;

	// Write lands on the release edge only
	assign dmem_we = ex.drw && !cpu_stall;

	always_ff @(posedge clk) begin
		if (rst) begin
			p <= '0;	// rf_we low out of reset
		end else if (!cpu_stall) begin
			p.rfw <= ex.rfw;
			p.wbsource <= ex.wbsource;
			p.alu_r <= ex.alu_r;
			p.rf_waddr <= ex.rf_waddr;
			p.jalra <= ex.jalra;
			p.dout <= dmem_rdata;	// Loaded word, ignored unless WB_MEM
		end
	end

	// A store reaches memory only after its wait states and never while frozen
	a_no_write_in_stall: assert property (
		@(posedge clk) disable iff (rst)
		dmem_we |-> !cpu_stall && $past(cpu_stall)
	) else $error("dmem write without a completed wait, addr %h", dmem_addr);

endmodule

// ==== rtl/cpu_wb.sv ====
// Writeback stage of the pipeline
// Picks the register file write data from the memory/writeback register
`timescale 1ns/100ps
`include "mem_params.svh"

module cpu_wb (
	input mem_pkg::mem_wb_t p,
	output logic rf_we,
	output mem_pkg::reg_addr_t rf_waddr,
	output mem_pkg::word_t rf_wdata
);

	always_comb begin
		case (p.wbsource)
			mem_pkg::WB_ALU: rf_wdata = p.alu_r;
			mem_pkg::WB_MEM: rf_wdata = p.dout;
			mem_pkg::WB_LINK: rf_wdata = p.jalra;
			default: rf_wdata = p.alu_r;	// Unused code, treat as ALU
		endcase
	end

	// Register 0 stays zero
	assign rf_we = p.rfw && (p.rf_waddr != `REG_ZERO);
	assign rf_waddr = p.rf_waddr;

endmodule

// ==== rtl/data_mem.sv ====
// Word-addressed data memory
// Read is combinational, write happens on the clock edge when we is high
// Contents start at zero in simulation
`timescale 1ns/100ps
`include "mem_params.svh"

module data_mem (
	input logic clk,
	input logic we,
	input logic [`DMEM_AW-1:0] addr,
	input mem_pkg::word_t wdata,
	output mem_pkg::word_t rdata
);

	localparam int DEPTH = 2 ** `DMEM_AW;

	mem_pkg::word_t mem [DEPTH];

	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	assign rdata = mem[addr];	// Async read, settles within the cycle

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

endmodule

// ==== rtl/dmem_stall_ctrl.sv ====
// Wait-state sequencer for the data memory
// Every load or store holds cpu_stall high for MEM_WAIT cycles, counting the
// cycle it is first seen, then gives one release cycle so it can complete
`timescale 1ns/100ps
`include "mem_params.svh"

module dmem_stall_ctrl (
	input logic clk,
	input logic rst,
	input logic ex_access,	// Load or store presented by execute
	input logic timer_last,
	output logic timer_load,
	output logic timer_en,
	output logic cpu_stall
);

	// More than the first stall cycle to wait out
	localparam bit MULTI = (`MEM_WAIT > 1);

	mem_pkg::stall_state_t state_q;
	mem_pkg::stall_state_t state_d;

	always_comb begin
		state_d = state_q;
		timer_load = 1'b0;
		timer_en = 1'b0;
		cpu_stall = 1'b0;
		case (state_q)
			mem_pkg::ST_IDLE: begin
				if (ex_access) begin
					cpu_stall = 1'b1;	// First wait cycle
					timer_load = 1'b1;
					timer_en = MULTI;	// This cycle counts as well
					state_d = MULTI ? mem_pkg::ST_WAIT : mem_pkg::ST_DONE;
				end
			end
			mem_pkg::ST_WAIT: begin
				cpu_stall = 1'b1;
				if (timer_last) begin
					state_d = mem_pkg::ST_DONE;	// Final wait cycle
				end else begin
					timer_en = 1'b1;
				end
			end
			mem_pkg::ST_DONE: begin
				// Same access still presented, let it through once
				state_d = mem_pkg::ST_IDLE;
			end
			default: state_d = mem_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= mem_pkg::ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

endmodule

// ==== rtl/dmem_wait_timer.sv ====
// Loadable down-counter for memory wait states
// load presets MEM_WAIT-1, en counts down, last is high at zero;
// a load and a count on the same edge give one less than the preset
`timescale 1ns/100ps
`include "mem_params.svh"

module dmem_wait_timer (
	input logic clk,
	input logic rst,
	input logic load,
	input logic en,
	output logic last
);

	localparam int CW = $clog2(`MEM_WAIT + 1);
	localparam logic [CW-1:0] LOAD_VAL = CW'(`MEM_WAIT - 1);

	logic [CW-1:0] cnt;
	logic [CW-1:0] cnt_base;	// Value the decrement applies to

	assign cnt_base = load ? LOAD_VAL : cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
		end else if (load || en) begin
			cnt <= cnt_base - CW'(en);
		end
	end

	assign last = (cnt == '0);

	// Controller must stop counting once the wait is used up
	a_no_underflow: assert property (
		@(posedge clk) disable iff (rst)
		en |-> cnt_base != '0
	) else $error("wait timer decremented past zero, load %b cnt %h", load, cnt);

endmodule

// ==== rtl/mem_params.svh ====
// Shared constants for the memory and writeback half of the pipeline
// Include in any file that needs the wait-state count or memory sizing
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Cycles each load or store holds the pipeline, 1 or more
`define MEM_WAIT 3

// Data memory word-address width, 64 words by default
`define DMEM_AW 6

// Hardwired zero register
`define REG_ZERO 5'd0

`endif

// ==== rtl/mem_pkg.sv ====
// Types shared by the memory stage, writeback stage and stall logic
// Refer to members by scoped name, e.g. mem_pkg::word_t
package mem_pkg;

	typedef logic [31:0] word_t;	// Data or address word
	typedef logic [4:0] reg_addr_t;	// Register file index

	// Writeback data source, encoding as driven by execute
	typedef enum logic [1:0] {
		WB_ALU = 2'd0,	// ALU result
		WB_MEM = 2'd1,	// Loaded word
		WB_LINK = 2'd2	// Return address for jal
	} wb_src_t;

	// Execute results handed to the memory stage
	typedef struct packed {
		logic rfw;	// Register write
		wb_src_t wbsource;
		logic drw;	// Data memory write
		word_t alu_r;	// Also the byte address for loads and stores
		word_t rfb;	// Store operand
		reg_addr_t rf_waddr;	// Destination register
		word_t jalra;	// Link address
		reg_addr_t rt;	// Store operand source register
	} ex_mem_t;

	// Memory/writeback pipeline register
	typedef struct packed {
		logic rfw;
		wb_src_t wbsource;
		word_t alu_r;
		reg_addr_t rf_waddr;
		word_t jalra;
		word_t dout;	// Word read from data memory
	} mem_wb_t;

	// Wait-state sequencer
	typedef enum logic [1:0] {
		ST_IDLE,	// No access in progress
		ST_WAIT,	// Holding the pipeline
		ST_DONE	// Release cycle, access completes
	} stall_state_t;

endpackage

// ==== rtl/mem_wb_top.sv ====
// Back half of the pipeline: memory stage, writeback stage, data memory
// and wait-state logic; execute results come in on ex
// ex must be held while cpu_stall is high
`timescale 1ns/100ps
`include "mem_params.svh"

module mem_wb_top (
	input logic clk,
	input logic rst,
	input mem_pkg::ex_mem_t ex,
	output logic rf_we,
	output mem_pkg::reg_addr_t rf_waddr,
	output mem_pkg::word_t rf_wdata,
	output logic cpu_stall
);

	mem_pkg::mem_wb_t p;	// Memory/writeback register
	logic [`DMEM_AW-1:0] dmem_addr;
	mem_pkg::word_t dmem_wdata;
	mem_pkg::word_t dmem_rdata;
	logic dmem_we;
	logic ex_access;
	logic timer_load;
	logic timer_en;
	logic timer_last;

	// Loads and stores both wait on the memory
	assign ex_access = ex.drw || (ex.wbsource == mem_pkg::WB_MEM);

	cpu_mem mem_i (
		.clk(clk),
		.rst(rst),
		.cpu_stall(cpu_stall),
		.ex(ex),
		.wb_wdata(rf_wdata),	// Forwarding source
		.dmem_rdata(dmem_rdata),
		.p(p),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_we(dmem_we)
	);

	cpu_wb wb_i (
		.p(p),
		.rf_we(rf_we),
		.rf_waddr(rf_waddr),
		.rf_wdata(rf_wdata)
	);

	data_mem dmem_i (
		.clk(clk),
		.we(dmem_we),
		.addr(dmem_addr),
		.wdata(dmem_wdata),
		.rdata(dmem_rdata)
	);

	dmem_stall_ctrl stall_i (
		.clk(clk),
		.rst(rst),
		.ex_access(ex_access),
		.timer_last(timer_last),
		.timer_load(timer_load),
		.timer_en(timer_en),
		.cpu_stall(cpu_stall)
	);

	dmem_wait_timer timer_i (
		.clk(clk),
		.rst(rst),
		.load(timer_load),
		.en(timer_en),
		.last(timer_last)
	);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it, and judges the run from its log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert -f src.f --top-module tb_mem_wb \
	-Mdir "$BUILD_DIR" -o sim_tb_mem_wb; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/sim_tb_mem_wb" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see $LOG"
	exit 1
fi

// ==== src.f ====
+incdir+rtl
rtl/mem_pkg.sv
rtl/cpu_mem.sv
rtl/cpu_wb.sv
rtl/dmem_stall_ctrl.sv
rtl/dmem_wait_timer.sv
rtl/data_mem.sv
rtl/mem_wb_top.sv
tests/tb_mem_wb.sv

// ==== tests/tb_mem_wb.sv ====
// Testbench for the memory and writeback half of the pipeline
// Feeds mem_wb_top a directed and a random instruction stream and checks the
// register file port and the stall level against a model of the stages
`timescale 1ns/100ps
`include "mem_params.svh"

module tb_mem_wb;

	localparam int N_RANDOM = 560;	// Random instructions between directed parts
	localparam int TIMEOUT_CYCLES = 600 * (`MEM_WAIT + 2);
	localparam int DEPTH = 2 ** `DMEM_AW;

	logic clk;
	logic rst;
	mem_pkg::ex_mem_t ex;
	logic rf_we;
	mem_pkg::reg_addr_t rf_waddr;
	mem_pkg::word_t rf_wdata;
	logic cpu_stall;

	logic [31:0] lcg_state = 32'hd978;
	int cycles = 0;
	int checks [1:5];
	int errs [1:5];

	mem_pkg::word_t mmem [DEPTH];	// Model memory
	logic exp_we;
	mem_pkg::reg_addr_t exp_waddr;
	mem_pkg::word_t exp_wdata;
	int exp_test;	// Test charged for writeback checks

	mem_wb_top dut_i (
		.clk(clk),
		.rst(rst),
		.ex(ex),
		.rf_we(rf_we),
		.rf_waddr(rf_waddr),
		.rf_wdata(rf_wdata),
		.cpu_stall(cpu_stall)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] lcg();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Upper bits only since the low ones repeat quickly
	function automatic int unsigned pick(int unsigned n);
		logic [31:0] r;
		r = lcg();
		return (r >> 16) % n;
	endfunction

	function automatic mem_pkg::word_t rand_word();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = lcg();
		lo = lcg();
		return {hi[31:16], lo[31:16]};
	endfunction

	// Word index into the byte address with upper bits kept as noise
	function automatic mem_pkg::word_t place_addr(mem_pkg::word_t r, int unsigned w);
		mem_pkg::word_t mask;
		mask = ((32'd1 << `DMEM_AW) - 32'd1) << 2;
		return (r & ~mask) | ((32'(w) << 2) & mask);
	endfunction

	function automatic mem_pkg::ex_mem_t make_op(input logic rfw, input mem_pkg::wb_src_t src,
			input logic drw, input mem_pkg::reg_addr_t waddr, input mem_pkg::reg_addr_t rt,
			input mem_pkg::word_t alu_r, input mem_pkg::word_t rfb);
		mem_pkg::ex_mem_t op;
		op = '0;
		op.rfw = rfw;
		op.wbsource = src;
		op.drw = drw;
		op.rf_waddr = waddr;
		op.rt = rt;
		op.alu_r = alu_r;
		op.rfb = rfb;
		return op;
	endfunction

	task automatic gen_random(output mem_pkg::ex_mem_t ins, output int test);
		int unsigned k;
		k = pick(12);
		ins = make_op(1'b1, mem_pkg::WB_ALU, 1'b0, 5'(pick(4)), 5'(pick(4)), rand_word(),
			rand_word());	// Registers 0 to 3 only so forwarding is common
		ins.jalra = rand_word();
		test = 2;
		if (k < 2) begin
			ins.wbsource = mem_pkg::WB_LINK;
		end else if (k < 5) begin
			ins.wbsource = mem_pkg::WB_MEM;	// Load
			ins.alu_r = place_addr(ins.alu_r, pick(16));
			test = 4;
		end else if (k < 8) begin
			ins.drw = 1'b1;	// Store
			ins.rfw = 1'b0;
			ins.alu_r = place_addr(ins.alu_r, pick(16));
		end else if (k == 8) begin
			ins.rfw = 1'b0;	// Bubble
		end
	endtask

	task automatic check_rf();
		assert (rf_we === exp_we) else begin
			$display("mismatch rf_we: got %h, expected %h", rf_we, exp_we);
			errs[exp_test]++;
		end
		if (exp_we) begin
			assert (rf_waddr === exp_waddr) else begin
				$display("mismatch rf_waddr: got %h, expected %h", rf_waddr, exp_waddr);
				errs[exp_test]++;
			end
			assert (rf_wdata === exp_wdata) else begin
				$display("mismatch rf_wdata: got %h, expected %h", rf_wdata, exp_wdata);
				errs[exp_test]++;
			end
		end
		checks[exp_test]++;
	endtask

	// Presents one instruction and holds it until the pipeline takes it
	task automatic issue(input mem_pkg::ex_mem_t ins, input int test);
		logic access;
		logic exp_stall;
		logic captured;
		logic fwd;
		int waits;
		logic [`DMEM_AW-1:0] idx;
		mem_pkg::word_t wdata;
		ex = ins;
		access = ins.drw || (ins.wbsource == mem_pkg::WB_MEM);
		waits = 0;
		captured = 1'b0;
		while (!captured) begin
			@(negedge clk);	// Outputs settled mid-cycle
			check_rf();
			exp_stall = access && (waits < `MEM_WAIT);
			assert (cpu_stall === exp_stall) else begin
				$display("mismatch cpu_stall: got %h, expected %h", cpu_stall, exp_stall);
				errs[3]++;
			end
			checks[3]++;
			captured = (cpu_stall === 1'b0);
			if (cpu_stall) begin
				waits++;
			end
			@(posedge clk);
		end
		idx = ins.alu_r[`DMEM_AW+1:2];
		fwd = exp_we && (ins.rt == exp_waddr);	// exp_we already excludes register 0
		wdata = fwd ? exp_wdata : ins.rfb;
		exp_we = ins.rfw && (ins.rf_waddr != `REG_ZERO);
		exp_waddr = ins.rf_waddr;
		case (ins.wbsource)
			mem_pkg::WB_MEM: exp_wdata = mmem[idx];	// Word before any write on this edge
			mem_pkg::WB_LINK: exp_wdata = ins.jalra;
			default: exp_wdata = ins.alu_r;
		endcase
		if (ins.drw) begin
			mmem[idx] = wdata;
		end
		exp_test = test;
		#1;	// Next instruction goes in just after the edge
	endtask

	task automatic report(input int t, input string name);
		$display("test %0d %s: %0d checks, %0d errors", t, name, checks[t], errs[t]);
	endtask

	initial begin
		mem_pkg::ex_mem_t ins;
		int test;
		int total_checks;
		int total_errs;
		rst = 1'b1;
		ex = '0;
		exp_we = 1'b0;
		exp_waddr = '0;
		exp_wdata = '0;
		exp_test = 2;
		for (int i = 0; i < DEPTH; i++) begin
			mmem[i] = '0;
		end
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		repeat (3) begin
			@(negedge clk);
			assert (rf_we === 1'b0) else begin
				$display("mismatch rf_we: got %h, expected %h", rf_we, 1'b0);
				errs[1]++;
			end
			assert (cpu_stall === 1'b0) else begin
				$display("mismatch cpu_stall: got %h, expected %h", cpu_stall, 1'b0);
				errs[1]++;
			end
			checks[1]++;
		end
		report(1, "reset");
		@(posedge clk);
		#1;
		// Words 20 and 21 lie above the random range so only the drain reads them
		issue(make_op(1'b1, mem_pkg::WB_ALU, 1'b0, 5'd2, 5'd0, 32'h1234_5678, '0), 2);
		issue(make_op(1'b0, mem_pkg::WB_ALU, 1'b1, 5'd0, 5'd2, place_addr('0, 20),
			32'hdead_beef), 2);
		issue(make_op(1'b1, mem_pkg::WB_ALU, 1'b0, 5'd0, 5'd0, 32'h0bad_f00d, '0), 2);
		issue(make_op(1'b0, mem_pkg::WB_ALU, 1'b1, 5'd0, 5'd0, place_addr('0, 21),
			32'h5a5a_a5a5), 2);
		for (int i = 0; i < N_RANDOM; i++) begin
			gen_random(ins, test);
			issue(ins, test);
		end
		// Read back every stored word
		for (int w = 0; w < 16; w++) begin
			issue(make_op(1'b1, mem_pkg::WB_MEM, 1'b0, 5'd1, 5'd0, place_addr('0, w), '0), 5);
		end
		issue(make_op(1'b1, mem_pkg::WB_MEM, 1'b0, 5'd1, 5'd0, place_addr('0, 20), '0), 5);
		issue(make_op(1'b1, mem_pkg::WB_MEM, 1'b0, 5'd1, 5'd0, place_addr('0, 21), '0), 5);
		issue('0, 2);	// Flushes the last load to the rf port
		report(2, "alu and link writeback");
		report(3, "stall length");
		report(4, "load data");
		report(5, "store forwarding");
		total_checks = 0;
		total_errs = 0;
		for (int t = 1; t <= 5; t++) begin
			total_checks += checks[t];
			total_errs += errs[t];
		end
		$display("total: %0d checks, %0d errors", total_checks, total_errs);
		if (total_errs == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// Run length guard
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("CHECKS FAILED");
			$finish;
		end
	end

endmodule
